/* Makefile */
# Verilator build and run of the memory front end testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = mem_front_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fails unless the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

/* logic/data_port.sv */
// data side load/store port
// one request at a time, held on the bus until memory accepts it
`default_nettype none
`timescale 1ns/1ps

module data_port (
	input  logic                     clock,
	input  logic                     reset,
	// request from the core side
	input  logic                     d_req,
	input  logic                     d_write,
	input  mem_front_pkg::addr_t     d_addr,
	input  mem_front_pkg::mem_word_t d_wdata,
	// status and result
	output logic                     d_busy,
	output logic                     d_done,
	output mem_front_pkg::mem_word_t d_rdata,
	// request toward the arbiter
	output mem_front_pkg::bus_cmd_t  d_cmd,
	output mem_front_pkg::addr_t     d_addr_out,
	output mem_front_pkg::mem_word_t d_data_out,
	// response and reply from memory
	input  mem_front_pkg::mem_tag_t  d_response,
	input  mem_front_pkg::mem_word_t mem_data,
	input  mem_front_pkg::mem_tag_t  mem_tag
);
	import mem_front_pkg::*;

	typedef enum logic [1:0] {
		idle,
		request,
		wait_data
	} state_t;

	state_t    state;
	// captured request
	logic      req_write;
	addr_t     req_addr;
	mem_word_t req_wdata;
	// tag of the outstanding load
	mem_tag_t  pend_tag;

	logic accepted;
	logic reply_seen;

	assign d_busy = (state != idle);

	// command only while the request is still unaccepted
	assign d_cmd      = (state != request) ? bus_none : (req_write ? bus_store : bus_load);
	assign d_addr_out = req_addr;
	assign d_data_out = req_wdata;

	assign accepted   = (state == request) && (d_response != '0);
	assign reply_seen = (state == wait_data) && (mem_tag == pend_tag);

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////

	// store ends on acceptance, load ends on its reply tag
	always_ff @(posedge clock) begin
		if (reset) begin
			state  <= idle;
			d_done <= 1'b0;
		end else begin
			d_done <= 1'b0;
			case (state)
				idle: begin
					if (d_req) begin
						state <= request;
					end
				end
				request: begin
					if (accepted && req_write) begin
						state  <= idle;
						d_done <= 1'b1;
					end else if (accepted) begin
						state <= wait_data;
					end
				end
				wait_data: begin
					if (reply_seen) begin
						state  <= idle;
						d_done <= 1'b1;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// request capture, tag capture, load result
	always_ff @(posedge clock) begin
		if (state == idle && d_req) begin
			req_write <= d_write;
			req_addr  <= d_addr;
			req_wdata <= d_wdata;
		end
		if (accepted) begin
			pend_tag <= d_response;
		end
		if (reply_seen) begin
			d_rdata <= mem_data;
		end
	end

	// the requester must wait for the port to drain
	no_req_while_busy: assert property (@(posedge clock) disable iff (reset)
		d_req |-> !d_busy)
		else $error("data request issued while the port was busy");

endmodule

`default_nettype wire

/* logic/icache.sv */
// direct-mapped instruction cache
// hits read combinationally and a miss loads the block over the shared bus
`default_nettype none
`timescale 1ns/1ps

module icache (
	input  logic                     clock,
	input  logic                     reset,
	// fetch side
	input  mem_front_pkg::addr_t     fetch_addr,
	output mem_front_pkg::mem_word_t fetch_data,
	output logic                     fetch_valid,
	// request toward the arbiter
	output mem_front_pkg::bus_cmd_t  i_cmd,
	output mem_front_pkg::addr_t     i_addr,
	// response and reply from memory
	input  mem_front_pkg::mem_tag_t  i_response,
	input  mem_front_pkg::mem_word_t mem_data,
	input  mem_front_pkg::mem_tag_t  mem_tag
);
	import mem_front_pkg::*;

	// miss handling
	typedef enum logic [1:0] {
		idle,
		wait_accept,
		wait_data
	} state_t;

	////////////////////////////////////////////////////////////
	// line storage
	////////////////////////////////////////////////////////////

	logic [ICACHE_LINES-1:0] line_valid;
	icache_tag_t             line_tag [ICACHE_LINES];
	mem_word_t               line_data [ICACHE_LINES];

	state_t   state;
	// tag handed out by memory for the fill in flight
	mem_tag_t pend_tag;
	// block being filled is held so a moving fetch_addr cannot corrupt the line
	addr_t    pend_addr;

	logic [INDEX_BITS-1:0] fetch_index;
	icache_tag_t           fetch_tag;
	addr_t                 fetch_block;
	logic [INDEX_BITS-1:0] fill_index;
	icache_tag_t           fill_tag;
	logic                  hit;
	logic                  accepted;
	logic                  fill_done;

	// split the fetch address
	assign fetch_index = fetch_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign fetch_tag   = fetch_addr[ADDR_BITS-1 -: ICACHE_TAG_BITS];
	assign fetch_block = {fetch_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};

	// same split for the stored fill address
	assign fill_index = pend_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign fill_tag   = pend_addr[ADDR_BITS-1 -: ICACHE_TAG_BITS];

	// hit path with no register in between
	assign hit         = line_valid[fetch_index] && (line_tag[fetch_index] == fetch_tag);
	assign fetch_valid = hit;
	assign fetch_data  = line_data[fetch_index];

	////////////////////////////////////////////////////////////
	// miss request
	////////////////////////////////////////////////////////////

	// idle asks for the current block at once and a retry replays the stored one
	always_comb begin
		i_cmd = bus_none;
		case (state)
			idle: begin
				if (!hit) begin
					i_cmd = bus_load;
				end
			end
			wait_accept: begin
				i_cmd = bus_load;
			end
			default: begin
				i_cmd = bus_none;
			end
		endcase
	end

	assign i_addr = (state == wait_accept) ? pend_addr : fetch_block;

	// nonzero response means memory took the load
	assign accepted  = (i_cmd != bus_none) && (i_response != '0);
	// our reply shows up with the tag we were given
	assign fill_done = (state == wait_data) && (mem_tag == pend_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (!hit) begin
						state <= accepted ? wait_data : wait_accept;
					end
				end
				wait_accept: begin
					if (accepted) begin
						state <= wait_data;
					end
				end
				wait_data: begin
					if (fill_done) begin
						state <= idle;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// fill bookkeeping
	always_ff @(posedge clock) begin
		if (state == idle && !hit) begin
			pend_addr <= fetch_block;
		end
		if (accepted) begin
			pend_tag <= i_response;
		end
	end

	////////////////////////////////////////////////////////////
	// line update
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			line_valid <= '0;
		end else if (fill_done) begin
			line_valid[fill_index] <= 1'b1;
		end
	end

	// tag and block written on the reply edge
	always_ff @(posedge clock) begin
		if (fill_done) begin
			line_tag[fill_index]  <= fill_tag;
			line_data[fill_index] <= mem_data;
		end
	end

	// an acceptance only ever answers a load that is on the bus
	response_needs_request: assert property (@(posedge clock) disable iff (reset)
		(i_cmd == bus_none) |-> (i_response == '0))
		else $error("icache saw an acceptance without a request on the bus");

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
// shared memory bus arbiter
// data side has priority and acceptance goes only to the bus owner
`default_nettype none
`timescale 1ns/1ps

module mem_arbiter (
	// instruction side request
	input  mem_front_pkg::bus_cmd_t  i_cmd,
	input  mem_front_pkg::addr_t     i_addr,
	// data side request
	input  mem_front_pkg::bus_cmd_t  d_cmd,
	input  mem_front_pkg::addr_t     d_addr_out,
	input  mem_front_pkg::mem_word_t d_data_out,
	// acceptance from memory
	input  mem_front_pkg::mem_tag_t  mem_response,
	// acceptance steered back
	output mem_front_pkg::mem_tag_t  i_response,
	output mem_front_pkg::mem_tag_t  d_response,
	// request on the shared bus
	output mem_front_pkg::bus_cmd_t  mem_cmd,
	output mem_front_pkg::addr_t     mem_addr,
	output mem_front_pkg::mem_word_t mem_wdata
);
	import mem_front_pkg::*;

	// data side owns the bus whenever it asks
	logic d_owns;

	assign d_owns = (d_cmd != bus_none);

	////////////////////////////////////////////////////////////
	// request mux
	////////////////////////////////////////////////////////////

	assign mem_cmd  = d_owns ? d_cmd : i_cmd;
	assign mem_addr = d_owns ? d_addr_out : i_addr;
	// instruction fetches carry no store data
	assign mem_wdata = d_owns ? d_data_out : '0;

	////////////////////////////////////////////////////////////
	// response steering
	////////////////////////////////////////////////////////////

	// loser sees zero and simply retries next cycle
	assign i_response = d_owns ? '0 : mem_response;
	assign d_response = d_owns ? mem_response : '0;

endmodule

`default_nettype wire

/* logic/mem_front.sv */
// memory front end top level
// instruction cache and data port sharing one tagged memory bus
`default_nettype none
`timescale 1ns/1ps

module mem_front (
	input  logic                     clock,
	input  logic                     reset,
	// instruction fetch
	input  mem_front_pkg::addr_t     fetch_addr,
	output mem_front_pkg::mem_word_t fetch_data,
	output logic                     fetch_valid,
	// data access
	input  logic                     d_req,
	input  logic                     d_write,
	input  mem_front_pkg::addr_t     d_addr,
	input  mem_front_pkg::mem_word_t d_wdata,
	output logic                     d_busy,
	output logic                     d_done,
	output mem_front_pkg::mem_word_t d_rdata,
	// memory bus
	output mem_front_pkg::bus_cmd_t  mem_cmd,
	output mem_front_pkg::addr_t     mem_addr,
	output mem_front_pkg::mem_word_t mem_wdata,
	input  mem_front_pkg::mem_tag_t  mem_response,
	input  mem_front_pkg::mem_word_t mem_data,
	input  mem_front_pkg::mem_tag_t  mem_tag
);
	import mem_front_pkg::*;

	////////////////////////////////////////////////////////////
	// requester to arbiter wiring
	////////////////////////////////////////////////////////////

	bus_cmd_t  i_cmd;
	addr_t     i_addr;
	mem_tag_t  i_response;
	bus_cmd_t  d_cmd;
	addr_t     d_addr_out;
	mem_word_t d_data_out;
	mem_tag_t  d_response;

	// reply tag and data fan out to both sides
	icache icache_i (
		.clock       (clock),
		.reset       (reset),
		.fetch_addr  (fetch_addr),
		.fetch_data  (fetch_data),
		.fetch_valid (fetch_valid),
		.i_cmd       (i_cmd),
		.i_addr      (i_addr),
		.i_response  (i_response),
		.mem_data    (mem_data),
		.mem_tag     (mem_tag)
	);

	data_port data_port_i (
		.clock      (clock),
		.reset      (reset),
		.d_req      (d_req),
		.d_write    (d_write),
		.d_addr     (d_addr),
		.d_wdata    (d_wdata),
		.d_busy     (d_busy),
		.d_done     (d_done),
		.d_rdata    (d_rdata),
		.d_cmd      (d_cmd),
		.d_addr_out (d_addr_out),
		.d_data_out (d_data_out),
		.d_response (d_response),
		.mem_data   (mem_data),
		.mem_tag    (mem_tag)
	);

	mem_arbiter mem_arbiter_i (
		.i_cmd        (i_cmd),
		.i_addr       (i_addr),
		.d_cmd        (d_cmd),
		.d_addr_out   (d_addr_out),
		.d_data_out   (d_data_out),
		.mem_response (mem_response),
		.i_response   (i_response),
		.d_response   (d_response),
		.mem_cmd      (mem_cmd),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata)
	);

endmodule

`default_nettype wire

/* logic/mem_front_pkg.sv */
// memory front end shared definitions
// bus widths, the bus command encoding and instruction cache geometry
`default_nettype none

package mem_front_pkg;

	////////////////////////////////////////////////////////////
	// memory bus widths
	////////////////////////////////////////////////////////////

	// byte address width
	localparam int ADDR_BITS = 32;
	// one bus word, also one cache block
	localparam int WORD_BITS = 64;
	// transaction tag, zero means no tag
	localparam int MEM_TAG_BITS = 4;

	typedef logic [ADDR_BITS-1:0] addr_t;
	typedef logic [WORD_BITS-1:0] mem_word_t;
	typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

	// bus command, same encoding as the memory side expects
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_cmd_t;

	////////////////////////////////////////////////////////////
	// instruction cache geometry
	////////////////////////////////////////////////////////////

	// direct mapped, one block per line
	localparam int ICACHE_LINES = 32;
	// byte offset inside an 8 byte block
	localparam int BLOCK_OFFSET_BITS = 3;
	// line index width
	localparam int INDEX_BITS = $clog2(ICACHE_LINES);
	// what is left of the address above index and offset
	localparam int ICACHE_TAG_BITS = ADDR_BITS - INDEX_BITS - BLOCK_OFFSET_BITS;

	typedef logic [ICACHE_TAG_BITS-1:0] icache_tag_t;

endpackage

`default_nettype wire

/* project.f */
logic/mem_front_pkg.sv
logic/icache.sv
logic/data_port.sv
logic/mem_arbiter.sv
logic/mem_front.sv
verification/mem_model.sv
verification/mem_front_checker.sv
verification/mem_front_tb.sv

/* verification/mem_front_checker.sv */
// front end checker
// shadow memory, fetch and load results, bus priority, retry and hit rules
`default_nettype none
`timescale 1ns/1ps

module mem_front_checker (
	input  logic                     clock,
	input  logic                     reset,
	input  mem_front_pkg::addr_t     fetch_addr,
	input  mem_front_pkg::mem_word_t fetch_data,
	input  logic                     fetch_valid,
	input  logic                     d_req,
	input  logic                     d_write,
	input  mem_front_pkg::addr_t     d_addr,
	input  mem_front_pkg::mem_word_t d_wdata,
	input  logic                     d_busy,
	input  logic                     d_done,
	input  mem_front_pkg::mem_word_t d_rdata,
	input  mem_front_pkg::bus_cmd_t  mem_cmd,
	input  mem_front_pkg::addr_t     mem_addr,
	input  mem_front_pkg::mem_word_t mem_wdata,
	input  mem_front_pkg::mem_tag_t  mem_response,
	input  mem_front_pkg::mem_tag_t  mem_tag,
	output int                       check_count,
	output int                       error_count
);
	import mem_front_pkg::*;

	mem_word_t shadow [addr_t];
	// data request still waiting for acceptance
	logic      req_open;
	logic      req_write_q;
	addr_t     req_addr_q;
	mem_word_t req_wdata_q;
	// expected port status
	logic      busy_exp;
	logic      done_exp;
	logic      load_wait;
	mem_tag_t  load_tag_q;
	// last bus cycle, for the retry rule
	logic      prev_reject;
	logic      prev_data;
	bus_cmd_t  prev_cmd;
	addr_t     prev_addr;
	// block each line is known to hold
	addr_t                   line_owner [ICACHE_LINES];
	logic [ICACHE_LINES-1:0] owner_known;
	// instruction fill in flight
	logic                    fill_open;
	mem_tag_t                fill_tag_q;
	logic [INDEX_BITS-1:0]   fill_idx_q;

	function automatic addr_t block_of(input addr_t a);
		return {a[ADDR_BITS-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
	endfunction

	// never written blocks hold their own address twice
	function automatic mem_word_t expected_word(input addr_t blk);
		if (shadow.exists(blk)) begin
			return shadow[blk];
		end
		return {blk, blk};
	endfunction

	task automatic flag_mismatch(input string sig, input mem_word_t got, input mem_word_t exp);
		$display("ERR %s got %h expected %h", sig, got, exp);
		error_count++;
	endtask

	always @(posedge clock) begin
		addr_t                 fblk;
		logic [INDEX_BITS-1:0] fidx;
		logic                  data_owns;
		bus_cmd_t              exp_cmd;
		if (reset) begin
			check_count = 0;
			error_count = 0;
			req_open    = 1'b0;
			prev_reject = 1'b0;
			owner_known = '0;
			busy_exp    = 1'b0;
			done_exp    = 1'b0;
			load_wait   = 1'b0;
			fill_open   = 1'b0;
		end else begin
			fblk = block_of(fetch_addr);
			fidx = fetch_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
			data_owns = req_open && d_busy;

			////////////////////////////////////////////////////////////
			// fetch side
			////////////////////////////////////////////////////////////

			if (fetch_valid) begin
				check_count++;
				if (fetch_data !== expected_word(fblk)) begin
					flag_mismatch("fetch_data", fetch_data, expected_word(fblk));
				end
				if (mem_cmd == bus_load && mem_addr == fblk) begin
					$display("icache loaded block %h while it was a hit", fblk);
					error_count++;
				end
			end
			// resident block must hit at once
			if (owner_known[fidx] && line_owner[fidx] == fblk) begin
				check_count++;
				if (fetch_valid !== 1'b1) begin
					flag_mismatch("fetch_valid", {63'h0, fetch_valid}, 64'h1);
				end
			end else begin
				// another block on this index may now replace the line
				owner_known[fidx] = 1'b0;
			end
			if (fetch_valid) begin
				owner_known[fidx] = 1'b1;
				line_owner[fidx]  = fblk;
			end
			// a fill in flight may replace its line at any edge
			if (fill_open) begin
				owner_known[fill_idx_q] = 1'b0;
				if (mem_tag == fill_tag_q) begin
					fill_open = 1'b0;
				end
			end
			// instruction load taken by memory
			if (!data_owns && mem_cmd == bus_load && mem_response != '0) begin
				fill_open  = 1'b1;
				fill_tag_q = mem_response;
				fill_idx_q = mem_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
			end

			////////////////////////////////////////////////////////////
			// bus priority and retry
			////////////////////////////////////////////////////////////

			if (data_owns) begin
				check_count++;
				exp_cmd = req_write_q ? bus_store : bus_load;
				if (mem_cmd !== exp_cmd) begin
					flag_mismatch("mem_cmd", {62'h0, mem_cmd}, {62'h0, exp_cmd});
				end
				if (mem_addr !== req_addr_q) begin
					flag_mismatch("mem_addr", {32'h0, mem_addr}, {32'h0, req_addr_q});
				end
				if (req_write_q && mem_wdata !== req_wdata_q) begin
					flag_mismatch("mem_wdata", mem_wdata, req_wdata_q);
				end
			end else if (mem_cmd != bus_none && mem_wdata !== '0) begin
				flag_mismatch("mem_wdata", mem_wdata, '0);
			end
			// rejected fetch replays unless the data side took over
			if (prev_reject && !prev_data && !data_owns) begin
				check_count++;
				if (mem_cmd !== prev_cmd) begin
					flag_mismatch("mem_cmd", {62'h0, mem_cmd}, {62'h0, prev_cmd});
				end
				if (mem_addr !== prev_addr) begin
					flag_mismatch("mem_addr", {32'h0, mem_addr}, {32'h0, prev_addr});
				end
			end
			prev_reject = (mem_cmd != bus_none) && (mem_response == '0);
			prev_data   = data_owns;
			prev_cmd    = mem_cmd;
			prev_addr   = mem_addr;

			////////////////////////////////////////////////////////////
			// data side
			////////////////////////////////////////////////////////////

			// busy from the edge after the strobe until completion
			check_count++;
			if (d_busy !== busy_exp) begin
				flag_mismatch("d_busy", {63'h0, d_busy}, {63'h0, busy_exp});
			end
			if (d_done !== done_exp) begin
				flag_mismatch("d_done", {63'h0, d_done}, {63'h0, done_exp});
			end
			done_exp = 1'b0;
			// load ends when its own reply tag comes back
			if (load_wait && mem_tag == load_tag_q) begin
				load_wait = 1'b0;
				busy_exp  = 1'b0;
				done_exp  = 1'b1;
			end
			// store lands in the shadow on acceptance
			if (data_owns && mem_response != '0) begin
				req_open = 1'b0;
				if (req_write_q) begin
					shadow[block_of(req_addr_q)] = req_wdata_q;
					busy_exp = 1'b0;
					done_exp = 1'b1;
				end else begin
					load_wait  = 1'b1;
					load_tag_q = mem_response;
				end
			end
			if (d_done && !req_write_q) begin
				check_count++;
				if (d_rdata !== expected_word(block_of(req_addr_q))) begin
					flag_mismatch("d_rdata", d_rdata, expected_word(block_of(req_addr_q)));
				end
			end
			if (d_req && !d_busy) begin
				req_open    = 1'b1;
				req_write_q = d_write;
				req_addr_q  = d_addr;
				req_wdata_q = d_wdata;
				busy_exp    = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* verification/mem_front_tb.sv */
// memory front end testbench
// random fetches in the low half and random loads and stores in the high half
`default_nettype none
`timescale 1ns/1ps

module mem_front_tb;
	import mem_front_pkg::*;

	localparam int DATA_REQUESTS = 150;
	localparam int WAIT_LIMIT    = 200;

	logic      clock;
	logic      reset;
	addr_t     fetch_addr;
	mem_word_t fetch_data;
	logic      fetch_valid;
	logic      d_req;
	logic      d_write;
	addr_t     d_addr;
	mem_word_t d_wdata;
	logic      d_busy;
	logic      d_done;
	mem_word_t d_rdata;
	bus_cmd_t  mem_cmd;
	addr_t     mem_addr;
	mem_word_t mem_wdata;
	mem_tag_t  mem_response;
	mem_word_t mem_data;
	mem_tag_t  mem_tag;
	int        check_count;
	int        error_count;
	integer    seed;
	integer    fetch_seed;
	int        timeouts;
	logic      fetch_stop;

	mem_front dut_i (.*);
	mem_model mem_model_i (.*);
	mem_front_checker checker_i (.*);

	always #10 clock = ~clock;

	// 64 instruction blocks from 0x4000 with two per cache line
	function automatic addr_t fetch_block(input logic [5:0] i);
		return {23'h000020, i, 3'b000};
	endfunction

	// 16 data blocks from 0x8000_0800
	function automatic addr_t data_block(input logic [3:0] i);
		return {25'h1000010, i, 3'b000};
	endfunction

	// fetch stream moves on after a hit or after a short random wait
	initial begin : fetch_stimulus
		int r;
		int t;
		repeat (3) @(posedge clock);
		while (!fetch_stop && timeouts == 0) begin
			@(posedge clock);
			r = $random(fetch_seed);
			if (r[2:0] != 3'd0) begin
				t = 0;
				while (fetch_valid !== 1'b1 && t < WAIT_LIMIT) begin
					@(posedge clock);
					t++;
				end
				if (t >= WAIT_LIMIT) begin
					$display("timeout: fetch of %h never became valid", fetch_addr);
					timeouts++;
				end
			end else begin
				repeat (1 + r[5:3]) @(posedge clock);
			end
			r = $random(fetch_seed);
			fetch_addr <= fetch_block(r[5:0]);
		end
	end

	initial begin
		int n;
		int r;
		int r2;
		int t;
		seed       = 44;
		fetch_seed = 44;
		clock      = 1'b0;
		reset      = 1'b1;
		fetch_addr = fetch_block(6'd0);
		d_req      = 1'b0;
		d_write    = 1'b0;
		d_addr     = '0;
		d_wdata    = '0;
		timeouts   = 0;
		fetch_stop = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		n = 0;
		while (n < DATA_REQUESTS && timeouts == 0) begin
			// port must be idle before a new strobe
			t = 0;
			while (d_busy !== 1'b0 && t < WAIT_LIMIT) begin
				@(posedge clock);
				t++;
			end
			if (t >= WAIT_LIMIT) begin
				$display("timeout: data port stayed busy");
				timeouts++;
			end else begin
				r  = $random(seed);
				r2 = $random(seed);
				d_req   <= 1'b1;
				d_write <= r[0];
				d_addr  <= data_block(r[4:1]);
				d_wdata <= {r, r2};
				@(posedge clock);
				d_req <= 1'b0;
				t = 0;
				while (d_done !== 1'b1 && t < WAIT_LIMIT) begin
					@(posedge clock);
					t++;
				end
				if (t >= WAIT_LIMIT) begin
					$display("timeout: data request to %h never finished", d_addr);
					timeouts++;
				end
				repeat (r[6:5]) @(posedge clock);
			end
			n++;
		end
		fetch_stop = 1'b1;
		repeat (4) @(posedge clock);
		$display("checks %0d  errors %0d  timeouts %0d", check_count, error_count, timeouts);
		if (error_count == 0 && timeouts == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/mem_model.sv */
// tagged memory model for the front end testbench
// random rejection, loads reply 2 to 6 cycles after acceptance
`default_nettype none
`timescale 1ns/1ps

module mem_model #(
	parameter int SEED = 44
) (
	input  logic                     clock,
	input  logic                     reset,
	input  mem_front_pkg::bus_cmd_t  mem_cmd,
	input  mem_front_pkg::addr_t     mem_addr,
	input  mem_front_pkg::mem_word_t mem_wdata,
	output mem_front_pkg::mem_tag_t  mem_response,
	output mem_front_pkg::mem_word_t mem_data,
	output mem_front_pkg::mem_tag_t  mem_tag
);
	import mem_front_pkg::*;

	integer    seed;
	// only written blocks are kept, the rest follow the fill pattern
	mem_word_t contents [addr_t];
	// loads in flight
	mem_tag_t  reply_tag_q [$];
	mem_word_t reply_data_q [$];
	int        reply_due_q [$];
	mem_tag_t  next_tag;
	logic      accept_roll;
	int        cycle;

	initial seed = SEED;

	// acceptance is combinational, a zero tag means try again
	assign mem_response = (mem_cmd != bus_none && accept_roll) ? next_tag : '0;

	function automatic mem_word_t read_block(input addr_t blk);
		if (contents.exists(blk)) begin
			return contents[blk];
		end
		return {blk, blk};
	endfunction

	always @(posedge clock) begin
		int    r;
		int    found;
		addr_t blk;
		if (reset) begin
			next_tag    <= 4'd1;
			accept_roll <= 1'b0;
			mem_tag     <= '0;
			mem_data    <= '0;
			cycle = 0;
			reply_tag_q.delete();
			reply_data_q.delete();
			reply_due_q.delete();
		end else begin
			cycle = cycle + 1;
			blk = {mem_addr[ADDR_BITS-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
			// accepted request
			if (mem_response != '0) begin
				if (mem_cmd == bus_store) begin
					contents[blk] = mem_wdata;
				end else begin
					r = $random(seed);
					reply_tag_q.push_back(mem_response);
					reply_data_q.push_back(read_block(blk));
					reply_due_q.push_back(cycle + 2 + ((r & 32'h7fff_ffff) % 5));
				end
				next_tag <= (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			end
			// at most one reply per cycle, a late one waits its turn
			mem_tag <= '0;
			found = -1;
			for (int i = 0; i < reply_due_q.size(); i++) begin
				if (found < 0 && reply_due_q[i] <= cycle) begin
					found = i;
				end
			end
			if (found >= 0) begin
				mem_tag  <= reply_tag_q[found];
				mem_data <= reply_data_q[found];
				reply_tag_q.delete(found);
				reply_data_q.delete(found);
				reply_due_q.delete(found);
			end
			// about one request in four gets turned away
			r = $random(seed);
			accept_roll <= (r[1:0] != 2'b00);
		end
	end

endmodule

`default_nettype wire
